//--- verilog/ip_hdr_pkg.sv
// ------------------------------
// Ethernet and IPv4 header fields as carried beside the payload
// no options, the header arrives in a single transfer
// ------------------------------
package ip_hdr_pkg;

    localparam int MAC_W      = 48;
    localparam int IP_ADDR_W  = 32;
    localparam int ETH_TYPE_W = 16;
    localparam int VERSION_W  = 4;
    localparam int IHL_W      = 4;
    localparam int DSCP_W     = 6;
    localparam int ECN_W      = 2;
    localparam int LENGTH_W   = 16;
    localparam int FLAGS_W    = 3;
    localparam int FRAG_W     = 13;
    localparam int TTL_W      = 8;
    localparam int PROTO_W    = 8;
    localparam int CSUM_W     = 16;

    // field order follows the wire order of the headers
    typedef struct packed {
        logic [MAC_W-1:0]      eth_dest_mac;
        logic [MAC_W-1:0]      eth_src_mac;
        logic [ETH_TYPE_W-1:0] eth_type;
        logic [VERSION_W-1:0]  version;
        logic [IHL_W-1:0]      ihl;
        logic [DSCP_W-1:0]     dscp;
        logic [ECN_W-1:0]      ecn;
        logic [LENGTH_W-1:0]   length;
        // identification is 16 bits, same as length
        logic [LENGTH_W-1:0]   identification;
        logic [FLAGS_W-1:0]    flags;
        logic [FRAG_W-1:0]     fragment_offset;
        logic [TTL_W-1:0]      ttl;
        logic [PROTO_W-1:0]    protocol;
        logic [CSUM_W-1:0]     header_checksum;
        logic [IP_ADDR_W-1:0]  source_ip;
        logic [IP_ADDR_W-1:0]  dest_ip;
    } ip_hdr_t;

endpackage

//--- verilog/demux_pkg.sv
// ------------------------------
// demux control types and default sizes
// defaults apply only where the top level is not overridden
// ------------------------------
package demux_pkg;

    // per-frame control state
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        FORWARD = 2'd1,
        DISCARD = 2'd2
    } frame_state_t;

    // output port count
    localparam int DEF_M_COUNT    = 4;

    // payload beat widths
    localparam int DEF_DATA_WIDTH = 8;
    localparam int DEF_USER_WIDTH = 1;

endpackage

//--- verilog/payload_if.sv
// ------------------------------
// one payload beat between the frame control and the output stage
// tvalid is one-hot or zero, one bit per output port
// ------------------------------
interface payload_if #(
    parameter int M_COUNT    = 4,
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
) ();

    logic [DATA_WIDTH-1:0] tdata;
    logic                  tlast;
    logic [USER_WIDTH-1:0] tuser;
    logic [M_COUNT-1:0]    tvalid;

    // output stage can take a beat on the next cycle
    logic                  ready_early;

    modport src (
        output tdata,
        output tlast,
        output tuser,
        output tvalid,
        input  ready_early
    );

    modport snk (
        input  tdata,
        input  tlast,
        input  tuser,
        input  tvalid,
        output ready_early
    );

endinterface

//--- verilog/frame_select_ctl.sv
// ------------------------------
// select and drop are sampled only when the header is accepted
// input readies are registered and gated by enable
// ------------------------------
module frame_select_ctl #(
    parameter int M_COUNT      = demux_pkg::DEF_M_COUNT,
    parameter int DATA_WIDTH   = demux_pkg::DEF_DATA_WIDTH,
    parameter int USER_WIDTH   = demux_pkg::DEF_USER_WIDTH,
    localparam int SEL_W       = (M_COUNT > 1) ? $clog2(M_COUNT) : 1
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  enable,
    input  logic                  drop,
    input  logic [SEL_W-1:0]      select,

    input  ip_hdr_pkg::ip_hdr_t   hdr_in,
    input  logic                  hdr_in_valid,
    output logic                  hdr_in_ready,

    output ip_hdr_pkg::ip_hdr_t   hdr_out,
    output logic [M_COUNT-1:0]    hdr_out_valid,
    input  logic [M_COUNT-1:0]    hdr_out_ready,

    input  logic [DATA_WIDTH-1:0] in_tdata,
    input  logic                  in_tvalid,
    input  logic                  in_tlast,
    input  logic [USER_WIDTH-1:0] in_tuser,
    output logic                  in_tready,

    payload_if.src                out
);

    demux_pkg::frame_state_t state_q, state_d;
    logic [SEL_W-1:0]        select_q;
    ip_hdr_pkg::ip_hdr_t     hdr_q;
    logic [M_COUNT-1:0]      hdr_valid_q, hdr_valid_d;
    logic                    hdr_in_ready_q, hdr_in_ready_d;
    logic                    in_tready_q, in_tready_d;
    logic                    hdr_accept;
    logic                    beat_accept;
    logic                    beat_fwd;

    assign hdr_in_ready  = hdr_in_ready_q && enable;
    assign in_tready     = in_tready_q && enable;
    assign hdr_out       = hdr_q;
    assign hdr_out_valid = hdr_valid_q;

    assign hdr_accept  = (state_q == demux_pkg::IDLE) && hdr_in_valid && hdr_in_ready;
    assign beat_accept = in_tvalid && in_tready;

    // in FORWARD the input ready is last cycle's ready_early
    assign beat_fwd = beat_accept && (state_q == demux_pkg::FORWARD);

    // beat routing
    assign out.tdata  = in_tdata;
    assign out.tlast  = in_tlast;
    assign out.tuser  = in_tuser;
    assign out.tvalid = M_COUNT'(beat_fwd) << select_q;

    always_comb begin
        state_d     = state_q;
        hdr_valid_d = hdr_valid_q & ~hdr_out_ready;

        // end of frame
        if (beat_accept && in_tlast) begin
            state_d = demux_pkg::IDLE;
        end

        // start of frame
        if (hdr_accept) begin
            state_d     = drop ? demux_pkg::DISCARD : demux_pkg::FORWARD;
            hdr_valid_d = M_COUNT'(!drop) << select;
        end

        // next header waits until every port has taken this one
        hdr_in_ready_d = (state_d == demux_pkg::IDLE) && !(|hdr_valid_d);

        case (state_d)
            demux_pkg::FORWARD: in_tready_d = out.ready_early;
            demux_pkg::DISCARD: in_tready_d = 1'b1;
            default:            in_tready_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q        <= demux_pkg::IDLE;
            select_q       <= '0;
            hdr_valid_q    <= '0;
            hdr_in_ready_q <= 1'b0;
            in_tready_q    <= 1'b0;
        end else begin
            state_q        <= state_d;
            hdr_valid_q    <= hdr_valid_d;
            hdr_in_ready_q <= hdr_in_ready_d;
            in_tready_q    <= in_tready_d;
            if (hdr_accept) begin
                select_q <= select;
            end
        end

        if (hdr_accept) begin
            hdr_q <= hdr_in;
        end
    end

    // at most one port sees the header
    a_hdr_valid_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(hdr_out_valid)
    );

    // a new header is never taken mid-frame
    a_hdr_ready_idle: assert property (
        @(posedge clk) disable iff (rst) hdr_in_ready |-> (state_q == demux_pkg::IDLE)
    );

endmodule

//--- verilog/payload_skid_buf.sv
// ------------------------------
// two-entry output stage, output register plus temp register
// all payload fields are shared, only tvalid is per port
// ------------------------------
module payload_skid_buf #(
    parameter int M_COUNT    = demux_pkg::DEF_M_COUNT,
    parameter int DATA_WIDTH = demux_pkg::DEF_DATA_WIDTH,
    parameter int USER_WIDTH = demux_pkg::DEF_USER_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    payload_if.snk                in,

    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic [M_COUNT-1:0]    m_tvalid,
    input  logic [M_COUNT-1:0]    m_tready,
    output logic                  m_tlast,
    output logic [USER_WIDTH-1:0] m_tuser
);

    // output register
    logic [DATA_WIDTH-1:0] out_data_q;
    logic                  out_last_q;
    logic [USER_WIDTH-1:0] out_user_q;
    logic [M_COUNT-1:0]    out_valid_q, out_valid_d;

    // temp register
    logic [DATA_WIDTH-1:0] tmp_data_q;
    logic                  tmp_last_q;
    logic [USER_WIDTH-1:0] tmp_user_q;
    logic [M_COUNT-1:0]    tmp_valid_q, tmp_valid_d;

    logic out_accept;
    logic out_busy;
    logic in_beat;
    logic tmp_full;
    logic load_out_from_in;
    logic load_tmp_from_in;
    logic load_out_from_tmp;

    assign m_tdata  = out_data_q;
    assign m_tvalid = out_valid_q;
    assign m_tlast  = out_last_q;
    assign m_tuser  = out_user_q;

    assign out_accept = |(m_tready & out_valid_q);
    assign out_busy   = |out_valid_q;
    assign in_beat    = |in.tvalid;
    assign tmp_full   = |tmp_valid_q;

    // ready next cycle unless the temp register would be needed then
    assign in.ready_early = out_accept || (!tmp_full && (!out_busy || !in_beat));

    always_comb begin
        out_valid_d       = out_valid_q;
        tmp_valid_d       = tmp_valid_q;
        load_out_from_in  = 1'b0;
        load_tmp_from_in  = 1'b0;
        load_out_from_tmp = 1'b0;

        if (in_beat) begin
            if (out_accept || !out_busy) begin
                // straight into the output register
                out_valid_d      = in.tvalid;
                load_out_from_in = 1'b1;
            end else begin
                // output stalled, park the beat
                tmp_valid_d      = in.tvalid;
                load_tmp_from_in = 1'b1;
            end
        end else if (out_accept) begin
            // temp may be empty, which just clears the output
            out_valid_d       = tmp_valid_q;
            tmp_valid_d       = '0;
            load_out_from_tmp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= '0;
            tmp_valid_q <= '0;
        end else begin
            out_valid_q <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
        end

        if (load_out_from_in) begin
            out_data_q <= in.tdata;
            out_last_q <= in.tlast;
            out_user_q <= in.tuser;
        end else if (load_out_from_tmp) begin
            out_data_q <= tmp_data_q;
            out_last_q <= tmp_last_q;
            out_user_q <= tmp_user_q;
        end

        if (load_tmp_from_in) begin
            tmp_data_q <= in.tdata;
            tmp_last_q <= in.tlast;
            tmp_user_q <= in.tuser;
        end
    end

    // the source honours ready_early, so the parked beat is never overwritten
    a_tmp_no_overwrite: assert property (
        @(posedge clk) disable iff (rst) load_tmp_from_in |-> !tmp_full
    );

endmodule

//--- verilog/ip_demux.sv
// ------------------------------
// IP frame demux, one input stream to M_COUNT output ports
// header fields and payload data are shared by all ports
// only the valid bits tell the ports apart
// ------------------------------
module ip_demux #(
    parameter int M_COUNT    = demux_pkg::DEF_M_COUNT,
    parameter int DATA_WIDTH = demux_pkg::DEF_DATA_WIDTH,
    parameter int USER_WIDTH = demux_pkg::DEF_USER_WIDTH,
    localparam int SEL_W     = (M_COUNT > 1) ? $clog2(M_COUNT) : 1
) (
    input  logic                                     clk,
    input  logic                                     rst,

    // header input
    input  logic                                     s_ip_hdr_valid,
    output logic                                     s_ip_hdr_ready,
    input  logic [ip_hdr_pkg::MAC_W-1:0]             s_eth_dest_mac,
    input  logic [ip_hdr_pkg::MAC_W-1:0]             s_eth_src_mac,
    input  logic [ip_hdr_pkg::ETH_TYPE_W-1:0]        s_eth_type,
    input  logic [ip_hdr_pkg::VERSION_W-1:0]         s_ip_version,
    input  logic [ip_hdr_pkg::IHL_W-1:0]             s_ip_ihl,
    input  logic [ip_hdr_pkg::DSCP_W-1:0]            s_ip_dscp,
    input  logic [ip_hdr_pkg::ECN_W-1:0]             s_ip_ecn,
    input  logic [ip_hdr_pkg::LENGTH_W-1:0]          s_ip_length,
    input  logic [ip_hdr_pkg::LENGTH_W-1:0]          s_ip_identification,
    input  logic [ip_hdr_pkg::FLAGS_W-1:0]           s_ip_flags,
    input  logic [ip_hdr_pkg::FRAG_W-1:0]            s_ip_fragment_offset,
    input  logic [ip_hdr_pkg::TTL_W-1:0]             s_ip_ttl,
    input  logic [ip_hdr_pkg::PROTO_W-1:0]           s_ip_protocol,
    input  logic [ip_hdr_pkg::CSUM_W-1:0]            s_ip_header_checksum,
    input  logic [ip_hdr_pkg::IP_ADDR_W-1:0]         s_ip_source_ip,
    input  logic [ip_hdr_pkg::IP_ADDR_W-1:0]         s_ip_dest_ip,

    // payload input
    input  logic [DATA_WIDTH-1:0]                    s_ip_payload_tdata,
    input  logic                                     s_ip_payload_tvalid,
    output logic                                     s_ip_payload_tready,
    input  logic                                     s_ip_payload_tlast,
    input  logic [USER_WIDTH-1:0]                    s_ip_payload_tuser,

    // header outputs, flattened per port
    output logic [M_COUNT-1:0]                       m_ip_hdr_valid,
    input  logic [M_COUNT-1:0]                       m_ip_hdr_ready,
    output logic [M_COUNT*ip_hdr_pkg::MAC_W-1:0]     m_eth_dest_mac,
    output logic [M_COUNT*ip_hdr_pkg::MAC_W-1:0]     m_eth_src_mac,
    output logic [M_COUNT*ip_hdr_pkg::ETH_TYPE_W-1:0] m_eth_type,
    output logic [M_COUNT*ip_hdr_pkg::VERSION_W-1:0] m_ip_version,
    output logic [M_COUNT*ip_hdr_pkg::IHL_W-1:0]     m_ip_ihl,
    output logic [M_COUNT*ip_hdr_pkg::DSCP_W-1:0]    m_ip_dscp,
    output logic [M_COUNT*ip_hdr_pkg::ECN_W-1:0]     m_ip_ecn,
    output logic [M_COUNT*ip_hdr_pkg::LENGTH_W-1:0]  m_ip_length,
    output logic [M_COUNT*ip_hdr_pkg::LENGTH_W-1:0]  m_ip_identification,
    output logic [M_COUNT*ip_hdr_pkg::FLAGS_W-1:0]   m_ip_flags,
    output logic [M_COUNT*ip_hdr_pkg::FRAG_W-1:0]    m_ip_fragment_offset,
    output logic [M_COUNT*ip_hdr_pkg::TTL_W-1:0]     m_ip_ttl,
    output logic [M_COUNT*ip_hdr_pkg::PROTO_W-1:0]   m_ip_protocol,
    output logic [M_COUNT*ip_hdr_pkg::CSUM_W-1:0]    m_ip_header_checksum,
    output logic [M_COUNT*ip_hdr_pkg::IP_ADDR_W-1:0] m_ip_source_ip,
    output logic [M_COUNT*ip_hdr_pkg::IP_ADDR_W-1:0] m_ip_dest_ip,

    // payload outputs, flattened per port
    output logic [M_COUNT*DATA_WIDTH-1:0]            m_ip_payload_tdata,
    output logic [M_COUNT-1:0]                       m_ip_payload_tvalid,
    input  logic [M_COUNT-1:0]                       m_ip_payload_tready,
    output logic [M_COUNT-1:0]                       m_ip_payload_tlast,
    output logic [M_COUNT*USER_WIDTH-1:0]            m_ip_payload_tuser,

    // control
    input  logic                                     enable,
    input  logic                                     drop,
    input  logic [SEL_W-1:0]                         select
);

    ip_hdr_pkg::ip_hdr_t   hdr_in;
    ip_hdr_pkg::ip_hdr_t   hdr_out;
    logic [DATA_WIDTH-1:0] pl_tdata;
    logic                  pl_tlast;
    logic [USER_WIDTH-1:0] pl_tuser;

    // pack the input fields
    assign hdr_in = '{
        eth_dest_mac:    s_eth_dest_mac,
        eth_src_mac:     s_eth_src_mac,
        eth_type:        s_eth_type,
        version:         s_ip_version,
        ihl:             s_ip_ihl,
        dscp:            s_ip_dscp,
        ecn:             s_ip_ecn,
        length:          s_ip_length,
        identification:  s_ip_identification,
        flags:           s_ip_flags,
        fragment_offset: s_ip_fragment_offset,
        ttl:             s_ip_ttl,
        protocol:        s_ip_protocol,
        header_checksum: s_ip_header_checksum,
        source_ip:       s_ip_source_ip,
        dest_ip:         s_ip_dest_ip
    };

    // captured header goes to every port
    assign m_eth_dest_mac       = {M_COUNT{hdr_out.eth_dest_mac}};
    assign m_eth_src_mac        = {M_COUNT{hdr_out.eth_src_mac}};
    assign m_eth_type           = {M_COUNT{hdr_out.eth_type}};
    assign m_ip_version         = {M_COUNT{hdr_out.version}};
    assign m_ip_ihl             = {M_COUNT{hdr_out.ihl}};
    assign m_ip_dscp            = {M_COUNT{hdr_out.dscp}};
    assign m_ip_ecn             = {M_COUNT{hdr_out.ecn}};
    assign m_ip_length          = {M_COUNT{hdr_out.length}};
    assign m_ip_identification  = {M_COUNT{hdr_out.identification}};
    assign m_ip_flags           = {M_COUNT{hdr_out.flags}};
    assign m_ip_fragment_offset = {M_COUNT{hdr_out.fragment_offset}};
    assign m_ip_ttl             = {M_COUNT{hdr_out.ttl}};
    assign m_ip_protocol        = {M_COUNT{hdr_out.protocol}};
    assign m_ip_header_checksum = {M_COUNT{hdr_out.header_checksum}};
    assign m_ip_source_ip       = {M_COUNT{hdr_out.source_ip}};
    assign m_ip_dest_ip         = {M_COUNT{hdr_out.dest_ip}};

    // payload fields likewise, tvalid picks the port
    assign m_ip_payload_tdata = {M_COUNT{pl_tdata}};
    assign m_ip_payload_tlast = {M_COUNT{pl_tlast}};
    assign m_ip_payload_tuser = {M_COUNT{pl_tuser}};

    payload_if #(
        .M_COUNT    (M_COUNT),
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) pl_if ();

    frame_select_ctl #(
        .M_COUNT    (M_COUNT),
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) u_ctl (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .drop          (drop),
        .select        (select),
        .hdr_in        (hdr_in),
        .hdr_in_valid  (s_ip_hdr_valid),
        .hdr_in_ready  (s_ip_hdr_ready),
        .hdr_out       (hdr_out),
        .hdr_out_valid (m_ip_hdr_valid),
        .hdr_out_ready (m_ip_hdr_ready),
        .in_tdata      (s_ip_payload_tdata),
        .in_tvalid     (s_ip_payload_tvalid),
        .in_tlast      (s_ip_payload_tlast),
        .in_tuser      (s_ip_payload_tuser),
        .in_tready     (s_ip_payload_tready),
        .out           (pl_if.src)
    );

    payload_skid_buf #(
        .M_COUNT    (M_COUNT),
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) u_skid (
        .clk      (clk),
        .rst      (rst),
        .in       (pl_if.snk),
        .m_tdata  (pl_tdata),
        .m_tvalid (m_ip_payload_tvalid),
        .m_tready (m_ip_payload_tready),
        .m_tlast  (pl_tlast),
        .m_tuser  (pl_tuser)
    );

endmodule

//--- tests/ip_demux_tb.sv
// ------------------------------
// ip_demux testbench, default parameters only
// frames come from tests/ip_demux_patterns.txt, run from the project root
// ------------------------------
module ip_demux_tb;

    localparam int M          = demux_pkg::DEF_M_COUNT;
    localparam int DW         = demux_pkg::DEF_DATA_WIDTH;
    localparam int UW         = demux_pkg::DEF_USER_WIDTH;
    localparam int SW         = $clog2(M);
    localparam int HW         = $bits(ip_hdr_pkg::ip_hdr_t);
    localparam int TIMEOUT    = 300;
    localparam int MAX_FRAMES = 32;

    logic                clk = 1'b0;
    logic                rst;
    logic                enable;
    logic                drop;
    logic [SW-1:0]       select;
    ip_hdr_pkg::ip_hdr_t drv_hdr;
    logic                s_ip_hdr_valid;
    wire                 s_ip_hdr_ready;
    logic [DW-1:0]       s_ip_payload_tdata;
    logic                s_ip_payload_tvalid;
    wire                 s_ip_payload_tready;
    logic                s_ip_payload_tlast;
    logic [UW-1:0]       s_ip_payload_tuser;

    wire  [M-1:0]        m_ip_hdr_valid;
    logic [M-1:0]        m_ip_hdr_ready;
    wire  [M*ip_hdr_pkg::MAC_W-1:0]      m_eth_dest_mac;
    wire  [M*ip_hdr_pkg::MAC_W-1:0]      m_eth_src_mac;
    wire  [M*ip_hdr_pkg::ETH_TYPE_W-1:0] m_eth_type;
    wire  [M*ip_hdr_pkg::VERSION_W-1:0]  m_ip_version;
    wire  [M*ip_hdr_pkg::IHL_W-1:0]      m_ip_ihl;
    wire  [M*ip_hdr_pkg::DSCP_W-1:0]     m_ip_dscp;
    wire  [M*ip_hdr_pkg::ECN_W-1:0]      m_ip_ecn;
    wire  [M*ip_hdr_pkg::LENGTH_W-1:0]   m_ip_length;
    wire  [M*ip_hdr_pkg::LENGTH_W-1:0]   m_ip_identification;
    wire  [M*ip_hdr_pkg::FLAGS_W-1:0]    m_ip_flags;
    wire  [M*ip_hdr_pkg::FRAG_W-1:0]     m_ip_fragment_offset;
    wire  [M*ip_hdr_pkg::TTL_W-1:0]      m_ip_ttl;
    wire  [M*ip_hdr_pkg::PROTO_W-1:0]    m_ip_protocol;
    wire  [M*ip_hdr_pkg::CSUM_W-1:0]     m_ip_header_checksum;
    wire  [M*ip_hdr_pkg::IP_ADDR_W-1:0]  m_ip_source_ip;
    wire  [M*ip_hdr_pkg::IP_ADDR_W-1:0]  m_ip_dest_ip;
    wire  [M*DW-1:0]     m_ip_payload_tdata;
    wire  [M-1:0]        m_ip_payload_tvalid;
    logic [M-1:0]        m_ip_payload_tready;
    wire  [M-1:0]        m_ip_payload_tlast;
    wire  [M*UW-1:0]     m_ip_payload_tuser;

    // select, drop, beat count, seed per frame
    logic [31:0]         pat [0:4*MAX_FRAMES-1];

    // expected traffic per output port, {tuser, tlast, tdata} per beat
    ip_hdr_pkg::ip_hdr_t exp_hdr [M][$];
    logic [UW+DW:0]      exp_beat [M][$];

    logic                en_last;
    logic [M-1:0]        hv_last;

    ip_demux DUT (
        .clk                  (clk),
        .rst                  (rst),
        .s_ip_hdr_valid       (s_ip_hdr_valid),
        .s_ip_hdr_ready       (s_ip_hdr_ready),
        .s_eth_dest_mac       (drv_hdr.eth_dest_mac),
        .s_eth_src_mac        (drv_hdr.eth_src_mac),
        .s_eth_type           (drv_hdr.eth_type),
        .s_ip_version         (drv_hdr.version),
        .s_ip_ihl             (drv_hdr.ihl),
        .s_ip_dscp            (drv_hdr.dscp),
        .s_ip_ecn             (drv_hdr.ecn),
        .s_ip_length          (drv_hdr.length),
        .s_ip_identification  (drv_hdr.identification),
        .s_ip_flags           (drv_hdr.flags),
        .s_ip_fragment_offset (drv_hdr.fragment_offset),
        .s_ip_ttl             (drv_hdr.ttl),
        .s_ip_protocol        (drv_hdr.protocol),
        .s_ip_header_checksum (drv_hdr.header_checksum),
        .s_ip_source_ip       (drv_hdr.source_ip),
        .s_ip_dest_ip         (drv_hdr.dest_ip),
        .s_ip_payload_tdata   (s_ip_payload_tdata),
        .s_ip_payload_tvalid  (s_ip_payload_tvalid),
        .s_ip_payload_tready  (s_ip_payload_tready),
        .s_ip_payload_tlast   (s_ip_payload_tlast),
        .s_ip_payload_tuser   (s_ip_payload_tuser),
        .m_ip_hdr_valid       (m_ip_hdr_valid),
        .m_ip_hdr_ready       (m_ip_hdr_ready),
        .m_eth_dest_mac       (m_eth_dest_mac),
        .m_eth_src_mac        (m_eth_src_mac),
        .m_eth_type           (m_eth_type),
        .m_ip_version         (m_ip_version),
        .m_ip_ihl             (m_ip_ihl),
        .m_ip_dscp            (m_ip_dscp),
        .m_ip_ecn             (m_ip_ecn),
        .m_ip_length          (m_ip_length),
        .m_ip_identification  (m_ip_identification),
        .m_ip_flags           (m_ip_flags),
        .m_ip_fragment_offset (m_ip_fragment_offset),
        .m_ip_ttl             (m_ip_ttl),
        .m_ip_protocol        (m_ip_protocol),
        .m_ip_header_checksum (m_ip_header_checksum),
        .m_ip_source_ip       (m_ip_source_ip),
        .m_ip_dest_ip         (m_ip_dest_ip),
        .m_ip_payload_tdata   (m_ip_payload_tdata),
        .m_ip_payload_tvalid  (m_ip_payload_tvalid),
        .m_ip_payload_tready  (m_ip_payload_tready),
        .m_ip_payload_tlast   (m_ip_payload_tlast),
        .m_ip_payload_tuser   (m_ip_payload_tuser),
        .enable               (enable),
        .drop                 (drop),
        .select               (select)
    );

    always #2 clk = ~clk;

    task automatic end_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        end_with_failure();
    endtask

    task automatic report_mismatch(input string test, input logic [HW-1:0] exp,
                                   input logic [HW-1:0] act);
        $display("ERROR %s expected %0h actual %0h", test, exp, act);
        end_with_failure();
    endtask

    // header fields from the frame seed
    function automatic ip_hdr_pkg::ip_hdr_t make_hdr(input logic [31:0] s);
        ip_hdr_pkg::ip_hdr_t h;
        h.eth_dest_mac    = {s[15:0], s};
        h.eth_src_mac     = {s, ~s[15:0]};
        h.eth_type        = 16'h0800;
        h.version         = 4'd4;
        h.ihl             = 4'd5;
        h.dscp            = s[5:0];
        h.ecn             = s[7:6];
        h.length          = s[31:16] ^ 16'h0014;
        h.identification  = s[15:0];
        h.flags           = s[10:8];
        h.fragment_offset = s[28:16];
        h.ttl             = s[23:16];
        h.protocol        = s[31:24];
        h.header_checksum = ~s[31:16];
        h.source_ip       = s;
        h.dest_ip         = {s[7:0], s[31:8]};
        return h;
    endfunction

    // payload beat i of a frame, {tuser, tlast, tdata}
    function automatic logic [UW+DW:0] make_beat(input logic [31:0] s, input int i,
                                                 input int cnt);
        logic [31:0] v;
        v = s + i;
        return {v[DW +: UW], i == cnt - 1, v[DW-1:0]};
    endfunction

    function automatic ip_hdr_pkg::ip_hdr_t port_hdr(input int p);
        ip_hdr_pkg::ip_hdr_t h;
        h.eth_dest_mac    = m_eth_dest_mac[p*ip_hdr_pkg::MAC_W +: ip_hdr_pkg::MAC_W];
        h.eth_src_mac     = m_eth_src_mac[p*ip_hdr_pkg::MAC_W +: ip_hdr_pkg::MAC_W];
        h.eth_type        = m_eth_type[p*ip_hdr_pkg::ETH_TYPE_W +: ip_hdr_pkg::ETH_TYPE_W];
        h.version         = m_ip_version[p*ip_hdr_pkg::VERSION_W +: ip_hdr_pkg::VERSION_W];
        h.ihl             = m_ip_ihl[p*ip_hdr_pkg::IHL_W +: ip_hdr_pkg::IHL_W];
        h.dscp            = m_ip_dscp[p*ip_hdr_pkg::DSCP_W +: ip_hdr_pkg::DSCP_W];
        h.ecn             = m_ip_ecn[p*ip_hdr_pkg::ECN_W +: ip_hdr_pkg::ECN_W];
        h.length          = m_ip_length[p*ip_hdr_pkg::LENGTH_W +: ip_hdr_pkg::LENGTH_W];
        h.identification  = m_ip_identification[p*ip_hdr_pkg::LENGTH_W +: ip_hdr_pkg::LENGTH_W];
        h.flags           = m_ip_flags[p*ip_hdr_pkg::FLAGS_W +: ip_hdr_pkg::FLAGS_W];
        h.fragment_offset = m_ip_fragment_offset[p*ip_hdr_pkg::FRAG_W +: ip_hdr_pkg::FRAG_W];
        h.ttl             = m_ip_ttl[p*ip_hdr_pkg::TTL_W +: ip_hdr_pkg::TTL_W];
        h.protocol        = m_ip_protocol[p*ip_hdr_pkg::PROTO_W +: ip_hdr_pkg::PROTO_W];
        h.header_checksum = m_ip_header_checksum[p*ip_hdr_pkg::CSUM_W +: ip_hdr_pkg::CSUM_W];
        h.source_ip       = m_ip_source_ip[p*ip_hdr_pkg::IP_ADDR_W +: ip_hdr_pkg::IP_ADDR_W];
        h.dest_ip         = m_ip_dest_ip[p*ip_hdr_pkg::IP_ADDR_W +: ip_hdr_pkg::IP_ADDR_W];
        return h;
    endfunction

    function automatic bit queues_empty();
        int p;
        for (p = 0; p < M; p++) begin
            if (exp_hdr[p].size() != 0 || exp_beat[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // one frame, header then payload with random gaps
    task automatic send_frame(input logic [SW-1:0] sel, input logic drp, input int cnt,
                              input logic [31:0] seed);
        ip_hdr_pkg::ip_hdr_t h;
        logic [UW+DW:0]      b;
        int                  i;
        int                  t;
        h = make_hdr(seed);
        if (!drp) begin
            exp_hdr[sel].push_back(h);
            for (i = 0; i < cnt; i++) begin
                exp_beat[sel].push_back(make_beat(seed, i, cnt));
            end
        end
        drv_hdr        <= h;
        select         <= sel;
        drop           <= drp;
        s_ip_hdr_valid <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            assert (t <= TIMEOUT) else report_failure("timeout waiting for s_ip_hdr_ready");
        end while (!s_ip_hdr_ready);
        s_ip_hdr_valid <= 1'b0;
        for (i = 0; i < cnt; i++) begin
            s_ip_payload_tvalid <= 1'b0;
            repeat ($urandom % 3) @(posedge clk);
            b = make_beat(seed, i, cnt);
            {s_ip_payload_tuser, s_ip_payload_tlast, s_ip_payload_tdata} <= b;
            s_ip_payload_tvalid <= 1'b1;
            t = 0;
            do begin
                @(posedge clk);
                t++;
                assert (t <= TIMEOUT)
                    else report_failure("timeout waiting for s_ip_payload_tready");
            end while (!s_ip_payload_tready);
        end
        s_ip_payload_tvalid <= 1'b0;
        s_ip_payload_tlast  <= 1'b0;
    endtask

    // random back-pressure on every output port
    always @(posedge clk) begin
        m_ip_hdr_ready      <= M'($urandom);
        m_ip_payload_tready <= M'($urandom);
    end

    // scoreboard, sees the values present just before each edge
    always @(posedge clk) begin : monitor
        ip_hdr_pkg::ip_hdr_t exp_h;
        logic [UW+DW:0]      exp_b;
        logic [UW+DW:0]      got_b;
        int                  p;
        if (!rst) begin
            for (p = 0; p < M; p++) begin
                if (m_ip_hdr_valid[p] && m_ip_hdr_ready[p]) begin
                    assert (exp_hdr[p].size() > 0)
                        else report_failure($sformatf("header on port %0d, none expected", p));
                    exp_h = exp_hdr[p].pop_front();
                    assert (port_hdr(p) == exp_h)
                        else report_mismatch($sformatf("header port %0d", p), exp_h,
                                             port_hdr(p));
                end
                if (m_ip_payload_tvalid[p] && m_ip_payload_tready[p]) begin
                    got_b = {m_ip_payload_tuser[p*UW +: UW], m_ip_payload_tlast[p],
                             m_ip_payload_tdata[p*DW +: DW]};
                    assert (exp_beat[p].size() > 0)
                        else report_failure($sformatf("beat on port %0d, none expected", p));
                    exp_b = exp_beat[p].pop_front();
                    assert (got_b == exp_b)
                        else report_mismatch($sformatf("payload port %0d", p), exp_b, got_b);
                end
            end
            assert ($onehot0(m_ip_hdr_valid) && $onehot0(m_ip_payload_tvalid))
                else report_failure("more than one output port valid at once");
            if (!enable) begin
                assert (!s_ip_hdr_ready && !s_ip_payload_tready)
                    else report_failure("input ready high while enable is low");
            end
            if (!en_last) begin
                assert ((m_ip_hdr_valid & ~hv_last) == '0)
                    else report_failure("header valid rose after enable went low");
            end
        end
        en_last = enable;
        hv_last = m_ip_hdr_valid;
    end

    // enable drops out for a few windows during traffic
    initial begin : enable_windows
        repeat (3) @(posedge clk);
        repeat (5) begin
            repeat (30 + $urandom % 40) @(posedge clk);
            enable <= 1'b0;
            repeat (12) @(posedge clk);
            enable <= 1'b1;
        end
    end

    initial begin : main
        int f;
        int t;
        int nframes;
        void'($urandom(32'h7f17));
        rst                 = 1'b1;
        enable              = 1'b1;
        drop                = 1'b0;
        select              = '0;
        drv_hdr             = '0;
        s_ip_hdr_valid      = 1'b0;
        s_ip_payload_tdata  = '0;
        s_ip_payload_tvalid = 1'b0;
        s_ip_payload_tlast  = 1'b0;
        s_ip_payload_tuser  = '0;
        m_ip_hdr_ready      = '0;
        m_ip_payload_tready = '0;
        en_last             = 1'b1;
        hv_last             = '0;
        // a zero beat count ends the frame list
        for (f = 0; f < 4 * MAX_FRAMES; f++) begin
            pat[f] = '0;
        end
        $readmemh("tests/ip_demux_patterns.txt", pat);

        @(posedge clk);
        @(posedge clk);
        assert (!s_ip_hdr_ready && m_ip_hdr_valid == '0 && m_ip_payload_tvalid == '0)
            else report_failure("ready or valid output high during reset");
        rst <= 1'b0;

        nframes = 0;
        for (f = 0; f < MAX_FRAMES && pat[4*f+2] != 0; f++) begin
            send_frame(pat[4*f][SW-1:0], pat[4*f+1][0], pat[4*f+2], pat[4*f+3]);
            nframes++;
        end
        assert (nframes > 0) else report_failure("no frames read from the pattern file");

        t = 0;
        while (!queues_empty()) begin
            @(negedge clk);
            t++;
            assert (t <= TIMEOUT)
                else report_failure("timeout waiting for the output queues to drain");
        end
        assert ((m_ip_hdr_valid | m_ip_payload_tvalid) == '0)
            else report_failure("output valid still high after the last frame");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- ip_demux.f
verilog/ip_hdr_pkg.sv
verilog/demux_pkg.sv
verilog/payload_if.sv
verilog/frame_select_ctl.sv
verilog/payload_skid_buf.sv
verilog/ip_demux.sv
tests/ip_demux_tb.sv

//--- tests/ip_demux_patterns.txt
// select drop beats seed, all hex, one frame per line
// header fields and payload bytes derive from seed plus beat index
0 0 4 1a2b3c40
1 0 1 0badf00d
2 1 6 5ee0aa10
3 0 8 77c30021
1 0 3 00123456
1 0 5 9e3779b9
0 1 2 deadbe00
2 0 10 c0ffee11
3 1 1 31415926
3 0 7 27182818
2 0 2 a5a5a500
0 0 c 13572468
1 1 4 fedcba98
0 0 1 66666601
2 0 9 4b1d0e77
